// File: sources.f
design/bot_io_pkg.sv
design/jstk_state_if.sv
design/panel_if.sv
design/jstk_decode.sv
design/io_port_regs.sv
design/seg_display_scan.sv
design/bot_io_top.sv
test/tb_bot_io_top.sv

// File: Bender.yml
package:
  name: bot_io

sources:
  - design/bot_io_pkg.sv
  - design/jstk_state_if.sv
  - design/panel_if.sv
  - design/jstk_decode.sv
  - design/io_port_regs.sv
  - design/seg_display_scan.sv
  - design/bot_io_top.sv
  - target: test
    files:
      - test/tb_bot_io_top.sv

// File: test/tb_bot_io_top.sv
// testbench for the bot i/o hub
// random joystick packets, port accesses, interrupt handshake and display scan
`timescale 1ns/10ps
`default_nettype none

module tb_bot_io_top;
    import bot_io_pkg::*;

    localparam int NUM_PKTS = 40;
    localparam int CLK_NS   = 40;
    localparam int WDOG_CYC = NUM_PKTS * 20 + 10 * NUM_DIGITS * SCAN_TICKS + 1000;

    logic        sysclk = 1'b0;
    logic        sysreset = 1'b1;
    logic [39:0] jstk_data = '0;
    logic        jstk_valid = 1'b0;
    logic [15:0] sw = '0;
    logic [7:0]  port_id = '0;
    logic [7:0]  out_port = '0;
    logic        write_strobe = 1'b0;
    logic        read_strobe = 1'b0;
    logic        interrupt_ack = 1'b0;
    logic [7:0]  loc_x = '0;
    logic [7:0]  loc_y = '0;
    logic [7:0]  bot_info = '0;
    logic [7:0]  sensors = '0;
    logic        upd_sysregs = 1'b0;
    logic [7:0]  in_port, mot_ctl;
    logic        interrupt, dp;
    logic [15:0] led;
    logic [6:0]  seg;
    logic [7:0]  an;

    // previous-cycle copies of the inputs to line up with the pipeline
    logic [7:0]  port_q = '0;
    logic [7:0]  port_q2 = '0;
    logic [7:0]  out_q = '0;
    logic [7:0]  out_q2 = '0;
    logic        wr_q = 1'b0;
    logic        wr_q2 = 1'b0;
    logic        upd_q = 1'b0;
    logic        ack_q = 1'b0;
    logic        int_q = 1'b0;
    logic [15:0] sw_q = '0;
    logic [2:0]  vld_d = '0;

    // expected state set where the stimulus is driven
    logic [7:0]  exp_flags = '0;
    logic [6:0]  exp_led = '0;
    logic [4:0]  exp_dig [5:7];
    logic [7:0]  exp_dp = '0;
    logic [7:0]  cap_x = '0;
    logic [7:0]  cap_y = '0;
    logic [7:0]  cap_info = '0;
    logic [7:0]  cap_sens = '0;
    logic        disp_en = 1'b0;
    logic [31:0] rng_state = 32'd33615;
    int          errors = 0;
    int          n;

    bot_io_top bot_io_top_inst (.*);

    always #(CLK_NS / 2) sysclk = ~sysclk;

    always @(posedge sysclk) begin
        port_q  <= port_id;
        port_q2 <= port_q;
        out_q   <= out_port;
        out_q2  <= out_q;
        wr_q    <= write_strobe;
        wr_q2   <= wr_q;
        sw_q    <= sw;
        upd_q   <= upd_sysregs;
        ack_q   <= interrupt_ack;
        int_q   <= interrupt;
        vld_d   <= {vld_d[1:0], jstk_valid};
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // lcg
        return rng_state;
    endfunction

    function automatic logic [6:0] seg_pattern(input logic [4:0] code);
        if (code[4]) return 7'b1111111;                  // blank
        case (code[3:0])                                 // active low {g..a}
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b0000011;
            4'hC:    return 7'b1000110;
            4'hD:    return 7'b0100001;
            4'hE:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    function automatic int digit_of(input logic [7:0] an_v);
        for (int k = 0; k < 8; k++)
            if (!an_v[k]) return k;
        return 0;
    endfunction

    function automatic logic [4:0] exp_code(input int k);
        if (k >= 5) return exp_dig[k];
        case (k)
            4:       return {2'b00, cap_info[2:0]};      // orientation
            3:       return {1'b0, cap_x[7:4]};
            2:       return {1'b0, cap_x[3:0]};
            1:       return {1'b0, cap_y[7:4]};
            default: return {1'b0, cap_y[3:0]};
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [47:0] exp_v,
                                   input logic [47:0] act_v);
        errors++;
        $display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
    endtask

    task automatic send_packet();
        logic [39:0] pkt;
        logic [9:0]  y, x;
        logic        fwd, back, left, right;
        pkt   = {next_rand(), next_rand()};
        y     = {pkt[9:8], pkt[23:16]};
        x     = {pkt[25:24], pkt[39:32]};
        fwd   = y >= 700;
        back  = y <= 300;
        left  = x <= 300;
        right = x >= 700;
        @(negedge sysclk);
        jstk_data  = pkt;
        jstk_valid = 1'b1;
        exp_flags  = {4'b0000, left, fwd, right, back};
        exp_led    = {fwd, back, left, right, pkt[1], pkt[2], pkt[0]};
        @(negedge sysclk);
        jstk_valid = 1'b0;
        repeat (5) @(negedge sysclk);
    endtask

    task automatic write_port(input logic [7:0] addr, input logic [7:0] data);
        @(negedge sysclk);
        port_id      = addr;
        out_port     = data;
        write_strobe = 1'b1;
        @(negedge sysclk);
        write_strobe = 1'b0;
        repeat (2) @(negedge sysclk);
    endtask

    task automatic read_port(input logic [7:0] addr);
        @(negedge sysclk);
        port_id = addr;                                  // address settles first
        @(negedge sysclk);
        read_strobe = 1'b1;
        @(negedge sysclk);
        read_strobe = 1'b0;
    endtask

    task automatic bot_update();
        @(negedge sysclk);
        loc_x       = next_rand();
        loc_y       = next_rand();
        bot_info    = next_rand();
        sensors     = next_rand();
        cap_x       = loc_x;
        cap_y       = loc_y;
        cap_info    = bot_info;
        cap_sens    = sensors;
        upd_sysregs = 1'b1;
        @(negedge sysclk);
        upd_sysregs = 1'b0;
        loc_x       = ~cap_x;                            // bot inputs move on after the pulse
        loc_y       = ~cap_y;
        bot_info    = ~cap_info;
        sensors     = ~cap_sens;
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // packed as {int, mot_ctl, led, an, seg} on byte boundaries
    a_rst_int: assert property (@(posedge sysclk)
        $fell(sysreset) |-> !interrupt && mot_ctl == 0 && led == 0
                            && an == 8'hFE && seg == 7'h7F)
        else report_mismatch("reset_state", 48'h00_00_0000_FE_7F,
                             {7'h00, $sampled(interrupt), $sampled(mot_ctl),
                              $sampled(led), $sampled(an), 1'b0, $sampled(seg)});
    a_jstk_rd: assert property (@(posedge sysclk) disable iff (sysreset)
        vld_d[1] && port_q == PORT_JSTK |-> in_port == exp_flags)
        else report_mismatch("jstk_read", exp_flags, $sampled(in_port));
    a_jstk_led: assert property (@(posedge sysclk) disable iff (sysreset)
        vld_d[2] |-> led[6:0] == exp_led)
        else report_mismatch("jstk_led", exp_led, $sampled(led[6:0]));
    a_sw_lo: assert property (@(posedge sysclk) disable iff (sysreset)
        port_q == PORT_SW_LO |-> in_port == sw_q[7:0])
        else report_mismatch("sw_lo_read", sw_q[7:0], $sampled(in_port));
    a_sw_hi: assert property (@(posedge sysclk) disable iff (sysreset)
        port_q == PORT_SW_HI |-> in_port == sw_q[15:8])
        else report_mismatch("sw_hi_read", sw_q[15:8], $sampled(in_port));
    a_motctl: assert property (@(posedge sysclk) disable iff (sysreset)
        wr_q && port_q == PORT_MOTCTL |-> mot_ctl == out_q)
        else report_mismatch("mot_ctl_write", out_q, $sampled(mot_ctl));
    a_leds: assert property (@(posedge sysclk) disable iff (sysreset)
        wr_q2 && port_q2 == PORT_LEDS |-> led[15:8] == out_q2)
        else report_mismatch("led_write", out_q2, $sampled(led[15:8]));
    a_int_rise: assert property (@(posedge sysclk) disable iff (sysreset)
        upd_q |-> interrupt)
        else report_mismatch("int_rise", 1, $sampled(interrupt));
    a_int_hold: assert property (@(posedge sysclk) disable iff (sysreset)
        int_q && !ack_q |-> interrupt)
        else report_mismatch("int_hold", 1, $sampled(interrupt));
    a_int_clear: assert property (@(posedge sysclk) disable iff (sysreset)
        ack_q && !upd_q |-> !interrupt)
        else report_mismatch("int_clear", 0, $sampled(interrupt));
    a_locx: assert property (@(posedge sysclk) disable iff (sysreset)
        port_q == PORT_LOCX |-> in_port == cap_x)
        else report_mismatch("locx_read", cap_x, $sampled(in_port));
    a_locy: assert property (@(posedge sysclk) disable iff (sysreset)
        port_q == PORT_LOCY |-> in_port == cap_y)
        else report_mismatch("locy_read", cap_y, $sampled(in_port));
    a_info: assert property (@(posedge sysclk) disable iff (sysreset)
        port_q == PORT_BOTINFO |-> in_port == cap_info)
        else report_mismatch("botinfo_read", cap_info, $sampled(in_port));
    a_sens: assert property (@(posedge sysclk) disable iff (sysreset)
        port_q == PORT_SENSORS |-> in_port == cap_sens)
        else report_mismatch("sensors_read", cap_sens, $sampled(in_port));
    a_seg: assert property (@(posedge sysclk) disable iff (sysreset)
        disp_en |-> seg == seg_pattern(exp_code(digit_of(an))))
        else report_mismatch("seg_digit", seg_pattern(exp_code(digit_of($sampled(an)))),
                             $sampled(seg));
    a_dp: assert property (@(posedge sysclk) disable iff (sysreset)
        disp_en |-> dp == !exp_dp[digit_of(an)])
        else report_mismatch("dp_digit", !exp_dp[digit_of($sampled(an))], $sampled(dp));
    a_an: assert property (@(posedge sysclk) disable iff (sysreset) $onehot(~an))
        else begin
            errors++;
            $display("anode select is not one-cold: an = %b", $sampled(an));
        end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        logic [7:0] d;
        for (int k = 5; k <= 7; k++) exp_dig[k] = 5'h10;
        repeat (8) @(negedge sysclk);
        sysreset = 1'b0;
        repeat (2) @(negedge sysclk);
        for (int i = 0; i < NUM_PKTS; i++) send_packet();
        for (int i = 0; i < 8; i++) begin
            @(negedge sysclk);
            sw = next_rand();
            read_port(PORT_SW_LO);
            read_port(PORT_SW_HI);
        end
        for (int i = 0; i < 6; i++) begin
            write_port(PORT_MOTCTL, next_rand());
            write_port(PORT_LEDS, next_rand());
        end
        for (int k = 5; k <= 7; k++) begin
            d = next_rand();
            write_port(8'h13 + 8'(7 - k), d);           // digit ports count down
            exp_dig[k] = d[4:0];
        end
        d = next_rand();
        write_port(PORT_DP_LO, d);
        exp_dp[3:0] = d[3:0];
        d = next_rand();
        write_port(PORT_DP_HI, d);
        exp_dp[7:4] = d[3:0];
        // second interrupt round updates twice before the ack
        for (int r = 0; r < 2; r++) begin
            @(negedge sysclk);
            port_id = PORT_JSTK;
            bot_update();
            if (r == 1) begin
                repeat (3) @(negedge sysclk);
                bot_update();
            end
            n = 0;
            while (!interrupt && n < 10) begin
                @(negedge sysclk);
                n++;
            end
            if (!interrupt) begin
                errors++;
                $display("interrupt did not rise after a bot update");
            end
            repeat (5) @(negedge sysclk);
            interrupt_ack = 1'b1;
            @(negedge sysclk);
            interrupt_ack = 1'b0;
            repeat (3) @(negedge sysclk);
            read_port(PORT_LOCX);
            read_port(PORT_LOCY);
            read_port(PORT_BOTINFO);
            read_port(PORT_SENSORS);
        end
        repeat (4) @(negedge sysclk);
        disp_en = 1'b1;
        repeat (2 * NUM_DIGITS * SCAN_TICKS) @(negedge sysclk);
        disp_en = 1'b0;
        repeat (2) @(negedge sysclk);
        $display("errors: %0d, packets sent: %0d", errors, NUM_PKTS);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WDOG_CYC) @(posedge sysclk);
        $display("timeout: run exceeded %0d cycles, errors: %0d", WDOG_CYC, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/bot_io_top.sv
// bot i/o hub top level
// joystick decode, controller port registers and display scan
`timescale 1ns/10ps
`default_nettype none

module bot_io_top (
    input  logic                              sysclk,
    input  logic                              sysreset,
    // joystick
    input  logic [bot_io_pkg::JSTK_PKT_W-1:0] jstk_data,
    input  logic                              jstk_valid,
    input  logic [15:0]                       sw,
    // controller port bus
    input  logic [bot_io_pkg::PORT_ID_W-1:0]  port_id,
    input  logic [bot_io_pkg::DATA_W-1:0]     out_port,
    input  logic                              write_strobe,
    input  logic                              read_strobe,
    output logic [bot_io_pkg::DATA_W-1:0]     in_port,
    output logic                              interrupt,
    input  logic                              interrupt_ack,
    // bot registers
    input  logic [bot_io_pkg::DATA_W-1:0]     loc_x,
    input  logic [bot_io_pkg::DATA_W-1:0]     loc_y,
    input  logic [bot_io_pkg::DATA_W-1:0]     bot_info,
    input  logic [bot_io_pkg::DATA_W-1:0]     sensors,
    input  logic                              upd_sysregs,
    // board outputs
    output logic [bot_io_pkg::DATA_W-1:0]     mot_ctl,
    output logic [15:0]                       led,
    output logic [6:0]                        seg,
    output logic                              dp,
    output logic [bot_io_pkg::NUM_DIGITS-1:0] an
);

    jstk_state_if jstk_state ();
    panel_if      panel ();

    jstk_decode jstk_decode_inst (
        .sysclk     (sysclk),
        .sysreset   (sysreset),
        .jstk_data  (jstk_data),
        .jstk_valid (jstk_valid),
        .jstk       (jstk_state.dec)
    );

    io_port_regs io_port_regs_inst (
        .sysclk        (sysclk),
        .sysreset      (sysreset),
        .sw            (sw),
        .port_id       (port_id),
        .out_port      (out_port),
        .write_strobe  (write_strobe),
        .read_strobe   (read_strobe),
        .in_port       (in_port),
        .interrupt     (interrupt),
        .interrupt_ack (interrupt_ack),
        .loc_x         (loc_x),
        .loc_y         (loc_y),
        .bot_info      (bot_info),
        .sensors       (sensors),
        .upd_sysregs   (upd_sysregs),
        .mot_ctl       (mot_ctl),
        .jstk          (jstk_state.regs),
        .panel         (panel.regs)
    );

    seg_display_scan seg_display_scan_inst (
        .sysclk   (sysclk),
        .sysreset (sysreset),
        .panel    (panel.disp),
        .seg      (seg),
        .dp       (dp),
        .an       (an),
        .led      (led)
    );

endmodule

`default_nettype wire

// File: design/seg_display_scan.sv
// eight digit seven segment scanner
// lights one digit per scan slot, also assembles the led bank
`timescale 1ns/10ps
`default_nettype none

module seg_display_scan (
    input  logic                              sysclk,
    input  logic                              sysreset,
    panel_if.disp                             panel,
    output logic [6:0]                        seg,   // active low cathodes
    output logic                              dp,    // active low
    output logic [bot_io_pkg::NUM_DIGITS-1:0] an,    // active low anodes
    output logic [15:0]                       led
);
    import bot_io_pkg::*;

    logic [SCAN_CNT_W-1:0]  tick_cnt;
    logic [DIGIT_IDX_W-1:0] digit_idx;
    logic [DIGIT_W-1:0]     cur_code;
    logic [6:0]             cur_pattern;

    // ----------------------------------------------------------
    // scan timing
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (sysreset) begin
            tick_cnt  <= '0;
            digit_idx <= '0;
        end else if (tick_cnt == SCAN_CNT_W'(SCAN_TICKS - 1)) begin
            tick_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1;         // wraps 7 -> 0
        end else begin
            tick_cnt  <= tick_cnt + 1'b1;
        end
    end

    assign cur_code    = panel.digits[digit_idx];
    assign cur_pattern = cur_code[4] ? SEG_BLANK : SEG_HEX[cur_code[3:0]];

    // seg, dp and an switch in the same edge, no ghosting
    always_ff @(posedge sysclk) begin
        if (sysreset) begin
            seg <= SEG_BLANK;
            dp  <= 1'b1;                           // point off
            an  <= ~NUM_DIGITS'(1);                // digit 0 selected
        end else begin
            seg <= cur_pattern;
            dp  <= ~panel.decpts[digit_idx];
            an  <= ~(NUM_DIGITS'(1) << digit_idx);
        end
    end

    // led bank, bit 7 left dark between the two groups
    always_ff @(posedge sysclk) begin
        if (sysreset) led <= 16'h0000;
        else          led <= {panel.leds_low, 1'b0, panel.jstk_led};
    end

    // exactly one anode low at any time
    a_an_one_cold: assert property (
        @(posedge sysclk) disable iff (sysreset)
        $onehot(~an)
    );

endmodule

`default_nettype wire

// File: design/io_port_regs.sv
// port mapped register file for the 8-bit controller
// bot register latch, update interrupt and panel register outputs
`timescale 1ns/10ps
`default_nettype none

module io_port_regs (
    input  logic                             sysclk,
    input  logic                             sysreset,
    input  logic [15:0]                      sw,
    input  logic [bot_io_pkg::PORT_ID_W-1:0] port_id,
    input  logic [bot_io_pkg::DATA_W-1:0]    out_port,
    input  logic                             write_strobe,
    input  logic                             read_strobe,
    output logic [bot_io_pkg::DATA_W-1:0]    in_port,
    output logic                             interrupt,
    input  logic                             interrupt_ack,
    input  logic [bot_io_pkg::DATA_W-1:0]    loc_x,
    input  logic [bot_io_pkg::DATA_W-1:0]    loc_y,
    input  logic [bot_io_pkg::DATA_W-1:0]    bot_info,
    input  logic [bot_io_pkg::DATA_W-1:0]    sensors,
    input  logic                             upd_sysregs,   // bot update pulse
    output logic [bot_io_pkg::DATA_W-1:0]    mot_ctl,
    jstk_state_if.regs                       jstk,
    panel_if.regs                            panel
);
    import bot_io_pkg::*;

    logic [DIGIT_W-1:0] dig7_q;
    logic [DIGIT_W-1:0] dig6_q;
    logic [DIGIT_W-1:0] dig5_q;
    logic [7:0]         decpts_q;
    logic [DATA_W-1:0]  leds_q;
    logic [6:0]         jstk_led_q;
    logic [DATA_W-1:0]  loc_x_q;
    logic [DATA_W-1:0]  loc_y_q;
    logic [DATA_W-1:0]  bot_info_q;
    logic [DATA_W-1:0]  sensors_q;

    // ----------------------------------------------------------
    // read path registers port_id every cycle
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        case (port_id)
            PORT_JSTK:    in_port <= {4'b0000, jstk.dir_left, jstk.dir_forward,
                                      jstk.dir_right, jstk.dir_back};
            PORT_SW_LO:   in_port <= sw[7:0];
            PORT_SW_HI:   in_port <= sw[15:8];
            PORT_LOCX:    in_port <= loc_x_q;
            PORT_LOCY:    in_port <= loc_y_q;
            PORT_BOTINFO: in_port <= bot_info_q;
            PORT_SENSORS: in_port <= sensors_q;
            default:      in_port <= '0;           // unmapped reads as zero
        endcase
    end

    // ----------------------------------------------------------
    // write path
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (sysreset) begin
            dig7_q   <= DIGIT_BLANK;
            dig6_q   <= DIGIT_BLANK;
            dig5_q   <= DIGIT_BLANK;
            decpts_q <= 8'h00;
            leds_q   <= '0;
            mot_ctl  <= '0;                        // bot stopped
        end else if (write_strobe) begin
            case (port_id)
                PORT_LEDS:   leds_q         <= out_port;
                PORT_DIG7:   dig7_q         <= out_port[DIGIT_W-1:0];
                PORT_DIG6:   dig6_q         <= out_port[DIGIT_W-1:0];
                PORT_DIG5:   dig5_q         <= out_port[DIGIT_W-1:0];
                PORT_DP_LO:  decpts_q[3:0]  <= out_port[3:0];
                PORT_DP_HI:  decpts_q[7:4]  <= out_port[3:0];
                PORT_MOTCTL: mot_ctl        <= out_port;
                default:     ;                     // read only or unmapped
            endcase
        end
    end

    // bot bytes recaptured on every update pulse
    always_ff @(posedge sysclk) begin
        if (sysreset) begin
            loc_x_q    <= '0;
            loc_y_q    <= '0;
            bot_info_q <= '0;
            sensors_q  <= '0;
        end else if (upd_sysregs) begin
            loc_x_q    <= loc_x;
            loc_y_q    <= loc_y;
            bot_info_q <= bot_info;
            sensors_q  <= sensors;
        end
    end

    // update sets interrupt and wins over a same-cycle ack
    always_ff @(posedge sysclk) begin
        if (sysreset) begin
            interrupt <= 1'b0;
        end else if (upd_sysregs) begin
            interrupt <= 1'b1;
        end else if (interrupt_ack) begin
            interrupt <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (sysreset) jstk_led_q <= 7'b0000000;
        else          jstk_led_q <= jstk.led_pattern;   // retime toward the leds
    end

    // ----------------------------------------------------------
    // panel drive
    // ----------------------------------------------------------
    assign panel.digits[7] = dig7_q;
    assign panel.digits[6] = dig6_q;
    assign panel.digits[5] = dig5_q;
    assign panel.digits[4] = {2'b00, bot_info_q[2:0]};   // orientation
    assign panel.digits[3] = {1'b0, loc_x_q[7:4]};
    assign panel.digits[2] = {1'b0, loc_x_q[3:0]};
    assign panel.digits[1] = {1'b0, loc_y_q[7:4]};
    assign panel.digits[0] = {1'b0, loc_y_q[3:0]};
    assign panel.decpts    = decpts_q;
    assign panel.leds_low  = leds_q;
    assign panel.jstk_led  = jstk_led_q;

    // an interrupt only ever follows a bot update
    a_int_after_upd: assert property (
        @(posedge sysclk) disable iff (sysreset)
        $rose(interrupt) |-> $past(upd_sysregs)
    );

    // controller holds the address a cycle ahead of its read strobe
    a_read_addr_settled: assert property (
        @(posedge sysclk) disable iff (sysreset)
        read_strobe |-> $stable(port_id)
    );

endmodule

`default_nettype wire

// File: design/jstk_decode.sv
// joystick packet decoder
// splits the 40-bit status packet into direction flags and button bits
`timescale 1ns/10ps
`default_nettype none

module jstk_decode (
    input  logic                              sysclk,
    input  logic                              sysreset,
    input  logic [bot_io_pkg::JSTK_PKT_W-1:0] jstk_data,
    input  logic                              jstk_valid,   // one cycle strobe
    jstk_state_if.dec                         jstk
);
    import bot_io_pkg::*;

    logic [JSTK_AXIS_W-1:0] jst_y;
    logic [JSTK_AXIS_W-1:0] jst_x;
    logic                   forward;
    logic                   back;
    logic                   left;
    logic                   right;

    // ----------------------------------------------------------
    // axis assembly, msb pair comes from the byte after the low byte
    // ----------------------------------------------------------
    assign jst_y = {jstk_data[9:8], jstk_data[23:16]};
    assign jst_x = {jstk_data[25:24], jstk_data[39:32]};

    assign forward = (jst_y >= JSTK_HIGH_MIN);
    assign back    = (jst_y <= JSTK_LOW_MAX);
    assign left    = (jst_x <= JSTK_LOW_MAX);
    assign right   = (jst_x >= JSTK_HIGH_MIN);

    // capture on valid packet, hold until the next one
    always_ff @(posedge sysclk) begin
        if (sysreset) begin
            jstk.dir_forward <= 1'b0;
            jstk.dir_back    <= 1'b0;
            jstk.dir_left    <= 1'b0;
            jstk.dir_right   <= 1'b0;
            jstk.btn         <= 3'b000;
            jstk.led_pattern <= 7'b0000000;
        end else if (jstk_valid) begin
            jstk.dir_forward <= forward;
            jstk.dir_back    <= back;
            jstk.dir_left    <= left;
            jstk.dir_right   <= right;
            jstk.btn         <= jstk_data[2:0];
            // buttons land swapped, b1 then b2 then b0
            jstk.led_pattern <= {forward, back, left, right,
                                 jstk_data[1], jstk_data[2], jstk_data[0]};
        end
    end

    // the stick cannot sit at both ends of the y axis
    a_no_fwd_and_back: assert property (
        @(posedge sysclk) disable iff (sysreset)
        !(jstk.dir_forward && jstk.dir_back)
    );

endmodule

`default_nettype wire

// File: design/panel_if.sv
// front panel state
// digit codes, decimal points and led bytes from port registers to scanner
`timescale 1ns/10ps
`default_nettype none

interface panel_if;
    import bot_io_pkg::*;

    logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digits;    // digit 7 is leftmost
    logic [NUM_DIGITS-1:0]              decpts;    // high = point lit
    logic [DATA_W-1:0]                  leds_low;  // controller led byte
    logic [6:0]                         jstk_led;  // joystick pattern

    modport regs (
        output digits, decpts, leds_low, jstk_led
    );

    modport disp (
        input  digits, decpts, leds_low, jstk_led
    );

endinterface

`default_nettype wire

// File: design/jstk_state_if.sv
// decoded joystick state
// registered flags and led pattern, decoder to port registers
`timescale 1ns/10ps
`default_nettype none

interface jstk_state_if;

    logic       dir_forward;   // y at or above high threshold
    logic       dir_back;      // y at or below low threshold
    logic       dir_left;
    logic       dir_right;
    logic [2:0] btn;           // stick buttons, packet byte 0
    logic [6:0] led_pattern;   // {fwd, back, left, right, b1, b2, b0}

    modport dec (
        output dir_forward, dir_back, dir_left, dir_right, btn, led_pattern
    );

    modport regs (
        input  dir_forward, dir_back, dir_left, dir_right, btn, led_pattern
    );

endinterface

`default_nettype wire

// File: design/bot_io_pkg.sv
// bot i/o hub shared constants
// port map, joystick thresholds, display scan timing and segment codes
`default_nettype none

package bot_io_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int DATA_W      = 8;    // controller data bus
    localparam int PORT_ID_W   = 8;    // port address
    localparam int JSTK_PKT_W  = 40;   // joystick status packet, 5 bytes
    localparam int JSTK_AXIS_W = 10;   // one axis value
    localparam int DIGIT_W     = 5;    // bit 4 blanks, 3:0 hex value
    localparam int NUM_DIGITS  = 8;
    localparam int DIGIT_IDX_W = $clog2(NUM_DIGITS);

    // axis thresholds, mid stick sits near 512
    localparam logic [JSTK_AXIS_W-1:0] JSTK_HIGH_MIN = 10'd700;   // fwd / right
    localparam logic [JSTK_AXIS_W-1:0] JSTK_LOW_MAX  = 10'd300;   // back / left

    // ----------------------------------------------------------
    // port addresses
    // ----------------------------------------------------------
    localparam logic [PORT_ID_W-1:0] PORT_JSTK    = 8'h00;
    localparam logic [PORT_ID_W-1:0] PORT_SW_LO   = 8'h01;
    localparam logic [PORT_ID_W-1:0] PORT_SW_HI   = 8'h11;
    localparam logic [PORT_ID_W-1:0] PORT_LEDS    = 8'h02;
    localparam logic [PORT_ID_W-1:0] PORT_DIG7    = 8'h13;
    localparam logic [PORT_ID_W-1:0] PORT_DIG6    = 8'h14;
    localparam logic [PORT_ID_W-1:0] PORT_DIG5    = 8'h15;
    localparam logic [PORT_ID_W-1:0] PORT_DP_LO   = 8'h07;   // decimal points 3:0
    localparam logic [PORT_ID_W-1:0] PORT_DP_HI   = 8'h17;   // decimal points 7:4
    localparam logic [PORT_ID_W-1:0] PORT_MOTCTL  = 8'h09;
    localparam logic [PORT_ID_W-1:0] PORT_LOCX    = 8'h0A;
    localparam logic [PORT_ID_W-1:0] PORT_LOCY    = 8'h0B;
    localparam logic [PORT_ID_W-1:0] PORT_BOTINFO = 8'h0C;
    localparam logic [PORT_ID_W-1:0] PORT_SENSORS = 8'h0D;

    // ----------------------------------------------------------
    // display
    // ----------------------------------------------------------
    localparam int SCAN_TICKS = 256;                    // sysclk cycles per digit
    localparam int SCAN_CNT_W = $clog2(SCAN_TICKS);

    localparam logic [DIGIT_W-1:0] DIGIT_BLANK = 5'h10; // blank code, bit 4 set

    // active low, bit order {g,f,e,d,c,b,a}
    localparam logic [15:0][6:0] SEG_HEX = {
        7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110,  // F E d C
        7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000,  // b A 9 8
        7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001,  // 7 6 5 4
        7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000   // 3 2 1 0
    };
    localparam logic [6:0] SEG_BLANK = 7'b1111111;      // all segments off

endpackage

`default_nettype wire
